// ==== cache_dir_config.svh ====
// ##########################################################################
// Cache tag directory geometry
// Sets, ways and tag width
// ##########################################################################
`ifndef CACHE_DIR_CONFIG_SVH
`define CACHE_DIR_CONFIG_SVH

// Number of sets, power of two
`define CACHE_SETS 8
// Ways per set
`define CACHE_WAYS 4
// Tag width in bits
`define CACHE_TAG_W 12

`endif

// ==== cache_dir_pkg.sv ====
// ##########################################################################
// Cache directory types
// Derived widths, request, response and operation encodings
// ##########################################################################
`default_nettype none
`include "cache_dir_config.svh"

package cache_dir_pkg;

    // Set index width from the set count
    localparam int unsigned set_w = $clog2(`CACHE_SETS);

    typedef logic [set_w-1:0]        set_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    // One bit per way
    typedef logic [`CACHE_WAYS-1:0]  way_vec_t;

    typedef enum logic {
        DIR_LOOKUP = 1'b0,
        DIR_INVAL  = 1'b1
    } dir_op_e;

    typedef struct packed {
        dir_op_e op;
        set_t    set_idx;
        tag_t    tag;
    } dir_req_t;

    // Hit way on hit or invalidate, victim way on miss
    typedef struct packed {
        logic     hit;
        way_vec_t way;
        logic     evict_valid;
        tag_t     evict_tag;
    } dir_rsp_t;

endpackage

`default_nettype wire

// ==== prio_1hot_encoder.sv ====
// ##########################################################################
// Priority encoder keeping the lowest set bit of a vector
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps

module prio_1hot_encoder #(
    parameter int unsigned N = 4
) (
    input  wire logic [N-1:0] val_i,
    output logic      [N-1:0] val_o
);

    // Bit i is high when any lower bit is set
    logic [N-1:0] seen;

    assign seen[0] = 1'b0;

    for (genvar i = 1; i < N; i++) begin : g_seen
        assign seen[i] = seen[i-1] | val_i[i-1];
    end

    // Only the first set bit survives, zero input gives zero
    assign val_o = val_i & ~seen;

endmodule

`default_nettype wire

// ==== cache_plru.sv ====
// ##########################################################################
// Pseudo-LRU state per set
// Victim way selection and PLRU bit update
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps
`include "cache_dir_config.svh"

module cache_plru (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // Update on lookup hit
    input  wire logic                    updt_i,
    input  wire cache_dir_pkg::set_t     updt_set_i,
    input  wire cache_dir_pkg::way_vec_t updt_way_i,

    // Replacement on lookup miss
    input  wire logic                    repl_i,
    input  wire cache_dir_pkg::set_t     repl_set_i,
    input  wire cache_dir_pkg::way_vec_t dir_valid_i,

    output cache_dir_pkg::way_vec_t      victim_way_o
);

    // One PLRU vector per set, bit high means recently used
    cache_dir_pkg::way_vec_t [`CACHE_SETS-1:0] plru_q;

    cache_dir_pkg::way_vec_t free_way;
    cache_dir_pkg::way_vec_t old_way;
    cache_dir_pkg::way_vec_t updt_plru;
    cache_dir_pkg::way_vec_t repl_plru;

    // Apply the used mark to a set's vector
    function automatic cache_dir_pkg::way_vec_t plru_next(
        input cache_dir_pkg::way_vec_t cur,
        input cache_dir_pkg::way_vec_t way
    );
        cache_dir_pkg::way_vec_t nxt;
        nxt = cur | way;
        // All ones would carry no age info
        // so restart from the accessed way
        if (&nxt) begin
            nxt = way;
        end
        return nxt;
    endfunction

    // First invalid way
    prio_1hot_encoder #(
        .N (`CACHE_WAYS)
    ) u_free_sel (
        .val_i (~dir_valid_i),
        .val_o (free_way)
    );

    // First way with a clear PLRU bit
    prio_1hot_encoder #(
        .N (`CACHE_WAYS)
    ) u_old_sel (
        .val_i (~plru_q[repl_set_i]),
        .val_o (old_way)
    );

    // Free way wins over the PLRU choice
    assign victim_way_o = (|free_way) ? free_way : old_way;

    // Next vectors for both update sources
    assign updt_plru = plru_next(plru_q[updt_set_i], updt_way_i);
    assign repl_plru = plru_next(plru_q[repl_set_i], victim_way_o);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            plru_q <= '0;
        end else begin
            // Miss and hit update are exclusive
            if (repl_i) begin
                plru_q[repl_set_i] <= repl_plru;
            end else if (updt_i) begin
                plru_q[updt_set_i] <= updt_plru;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_tag_dir.sv ====
// ##########################################################################
// Tag and valid storage per set and way
// Tag compare, tag write and invalidate
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps
`include "cache_dir_config.svh"

module cache_tag_dir (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // Read side, also addresses writes
    input  wire cache_dir_pkg::set_t     rd_set_i,
    input  wire cache_dir_pkg::tag_t     rd_tag_i,
    output cache_dir_pkg::way_vec_t      hit_way_o,
    output cache_dir_pkg::way_vec_t      valid_o,
    output cache_dir_pkg::tag_t [`CACHE_WAYS-1:0] tags_o,

    // Tag write into one way
    input  wire logic                    wr_i,
    input  wire cache_dir_pkg::way_vec_t wr_way_i,

    // Valid clear in any ways
    input  wire logic                    inval_i,
    input  wire cache_dir_pkg::way_vec_t inval_way_i
);

    // Tag array, packed by way
    cache_dir_pkg::tag_t [`CACHE_WAYS-1:0] tag_q [`CACHE_SETS];
    // Valid bits per set
    cache_dir_pkg::way_vec_t [`CACHE_SETS-1:0] valid_q;

    // Combinational read of the addressed set
    assign tags_o  = tag_q[rd_set_i];
    assign valid_o = valid_q[rd_set_i];

    // Compare every way, qualified by valid
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_way_o[w] = valid_o[w] && (tags_o[w] == rd_tag_i);
        end
    end

    // Tag storage
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wr_i && wr_way_i[w]) begin
                tag_q[rd_set_i][w] <= rd_tag_i;
            end
        end
    end

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (wr_i) begin
                valid_q[rd_set_i] <= valid_q[rd_set_i] | wr_way_i;
            end else if (inval_i) begin
                // Clears every matching way
                valid_q[rd_set_i] <= valid_q[rd_set_i] & ~inval_way_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cache_dir_top.sv ====
// ##########################################################################
// Cache tag directory top
// Request handshake, operation decode, response register
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps
`include "cache_dir_config.svh"

module cache_dir_top (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // Request channel
    input  wire logic                    req_valid_i,
    output logic                         req_ready_o,
    input  wire cache_dir_pkg::dir_req_t req_i,

    // Response channel
    output logic                         rsp_valid_o,
    input  wire logic                    rsp_ready_i,
    output cache_dir_pkg::dir_rsp_t      rsp_o
);

    logic                                  accept;
    logic                                  is_lookup;
    logic                                  hit;
    cache_dir_pkg::way_vec_t               hit_way;
    cache_dir_pkg::way_vec_t               dir_valid;
    cache_dir_pkg::tag_t [`CACHE_WAYS-1:0] dir_tags;
    cache_dir_pkg::way_vec_t               victim_way;
    logic                                  updt;
    logic                                  repl;
    logic                                  inval;
    logic                                  evict_valid;
    cache_dir_pkg::tag_t                   evict_tag;
    cache_dir_pkg::dir_rsp_t               rsp_d;
    cache_dir_pkg::dir_rsp_t               rsp_q;
    logic                                  rsp_valid_q;

    // Free slot or slot being drained
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    // Operation decode, strobes only on the accepting cycle
    assign is_lookup = (req_i.op == cache_dir_pkg::DIR_LOOKUP);
    assign hit       = |hit_way;
    assign updt      = accept && is_lookup && hit;
    assign repl      = accept && is_lookup && !hit;
    assign inval     = accept && !is_lookup;

    cache_tag_dir u_tag_dir (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_set_i    (req_i.set_idx),
        .rd_tag_i    (req_i.tag),
        .hit_way_o   (hit_way),
        .valid_o     (dir_valid),
        .tags_o      (dir_tags),
        .wr_i        (repl),
        .wr_way_i    (victim_way),
        .inval_i     (inval),
        .inval_way_i (hit_way)
    );

    cache_plru u_plru (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .updt_i       (updt),
        .updt_set_i   (req_i.set_idx),
        .updt_way_i   (hit_way),
        .repl_i       (repl),
        .repl_set_i   (req_i.set_idx),
        .dir_valid_i  (dir_valid),
        .victim_way_o (victim_way)
    );

    // Old content of the victim way
    assign evict_valid = |(victim_way & dir_valid);

    always_comb begin
        evict_tag = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (victim_way[w]) begin
                evict_tag = evict_tag | dir_tags[w];
            end
        end
    end

    // Response payload
    always_comb begin
        rsp_d     = '0;
        rsp_d.hit = hit;
        rsp_d.way = hit_way;
        // Miss reports the allocated way and what it held
        if (is_lookup && !hit) begin
            rsp_d.way         = victim_way;
            rsp_d.evict_valid = evict_valid;
            rsp_d.evict_tag   = evict_tag;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Payload held until the next accepted request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== tb_cache_dir.sv ====
// ##########################################################################
// Testbench for the cache tag directory
// Reference model, response checker, directed and random traffic
// ##########################################################################
`default_nettype none
`timescale 1ns/1ps
`include "cache_dir_config.svh"

module tb_cache_dir;

    localparam int TIMEOUT = 200;
    localparam int N_RAND  = 400;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    req_valid_i;
    logic                    req_ready_o;
    cache_dir_pkg::dir_req_t req_i;
    logic                    rsp_valid_o;
    logic                    rsp_ready_i;
    cache_dir_pkg::dir_rsp_t rsp_o;

    // Model state: tags, valid bits and PLRU bits per set
    cache_dir_pkg::tag_t     m_tag [`CACHE_SETS][`CACHE_WAYS];
    cache_dir_pkg::way_vec_t m_valid [`CACHE_SETS];
    cache_dir_pkg::way_vec_t m_plru [`CACHE_SETS];

    cache_dir_pkg::dir_rsp_t exp_q[$];
    bit                      tag_chk_q[$];
    cache_dir_pkg::dir_req_t rand_req [N_RAND];
    cache_dir_pkg::dir_rsp_t exp_rsp;
    cache_dir_pkg::dir_rsp_t held_rsp;
    bit                      held;
    bit                      stall_en;
    integer                  seed;
    int                      rnd;
    int                      stall_rnd;
    int                      sent_cnt;
    int                      acc_cnt;
    int                      rsp_cnt;
    int                      wait_cnt;

    cache_dir_top u_cache_dir_top (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    // Mark a way as used; a set that would become all ones keeps only this way
    function automatic void mark_used(input cache_dir_pkg::set_t s,
                                      input cache_dir_pkg::way_vec_t way);
        if ((m_plru[s] | way) == {`CACHE_WAYS{1'b1}}) begin
            m_plru[s] = way;
        end else begin
            m_plru[s] = m_plru[s] | way;
        end
    endfunction

    // Expected response for one accepted request, model state updated
    function automatic cache_dir_pkg::dir_rsp_t model_access(input cache_dir_pkg::dir_req_t r);
        cache_dir_pkg::dir_rsp_t rsp;
        cache_dir_pkg::way_vec_t match;
        int                      vic;
        rsp   = '0;
        match = '0;
        vic   = -1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = m_valid[r.set_idx][w] && (m_tag[r.set_idx][w] == r.tag);
        end
        rsp.hit = |match;
        rsp.way = match;
        if (r.op == cache_dir_pkg::DIR_INVAL) begin
            m_valid[r.set_idx] = m_valid[r.set_idx] & ~match;
        end else if (rsp.hit) begin
            mark_used(r.set_idx, match);
        end else begin
            // Lowest invalid way first, then lowest way with a clear PLRU bit
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (vic < 0 && !m_valid[r.set_idx][w]) begin
                    vic = w;
                end
            end
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (vic < 0 && !m_plru[r.set_idx][w]) begin
                    vic = w;
                end
            end
            rsp.way[vic]            = 1'b1;
            rsp.evict_valid         = m_valid[r.set_idx][vic];
            rsp.evict_tag           = rsp.evict_valid ? m_tag[r.set_idx][vic] : '0;
            m_tag[r.set_idx][vic]   = r.tag;
            m_valid[r.set_idx][vic] = 1'b1;
            mark_used(r.set_idx, rsp.way);
        end
        return rsp;
    endfunction

    // Drive one request and wait until it is accepted
    task automatic send_req(input cache_dir_pkg::dir_op_e op, input cache_dir_pkg::set_t s,
                            input cache_dir_pkg::tag_t t);
        int cnt;
        @(negedge clk_i);
        req_valid_i   = 1'b1;
        req_i.op      = op;
        req_i.set_idx = s;
        req_i.tag     = t;
        cnt = 0;
        #1;
        while (!req_ready_o && cnt < TIMEOUT) begin
            cnt++;
            @(negedge clk_i);
            #1;
        end
        if (!req_ready_o) begin
            fail_run("Request was not accepted before the timeout");
        end
        sent_cnt++;
    endtask

    // Random back-pressure, ready about three cycles in four
    always @(negedge clk_i) begin
        if (stall_en) begin
            stall_rnd   = $random(seed);
            rsp_ready_i = (stall_rnd[1:0] != 2'b00);
        end else begin
            rsp_ready_i = 1'b1;
        end
    end

    // Checker samples just after the falling edge when everything is settled
    always @(negedge clk_i) begin
        #1;
        if (rst_ni) begin
            // Response valid exactly while the model has one outstanding
            check_val("rsp_valid_o", 32'(rsp_valid_o), 32'(exp_q.size() != 0));
            // Ready when no response is pending or it drains now
            check_val("req_ready_o", 32'(req_ready_o),
                      32'(exp_q.size() == 0 || rsp_ready_i));
            // Stalled response must not move
            if (held) begin
                check_val("rsp_valid_o", 32'(rsp_valid_o), 32'd1);
                check_val("rsp_o", 32'(rsp_o), 32'(held_rsp));
            end
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_q.size() == 0) begin
                    fail_run("A response arrived with no request outstanding");
                end else begin
                    exp_rsp = exp_q.pop_front();
                    check_val("rsp_o.hit", 32'(rsp_o.hit), 32'(exp_rsp.hit));
                    check_val("rsp_o.way", 32'(rsp_o.way), 32'(exp_rsp.way));
                    check_val("rsp_o.evict_valid", 32'(rsp_o.evict_valid),
                              32'(exp_rsp.evict_valid));
                    // Tag of a never-written victim is undefined
                    if (tag_chk_q.pop_front()) begin
                        check_val("rsp_o.evict_tag", 32'(rsp_o.evict_tag),
                                  32'(exp_rsp.evict_tag));
                    end
                    rsp_cnt++;
                end
            end
            if (req_valid_i && req_ready_o) begin
                exp_rsp = model_access(req_i);
                exp_q.push_back(exp_rsp);
                tag_chk_q.push_back(exp_rsp.hit || exp_rsp.evict_valid ||
                                    req_i.op == cache_dir_pkg::DIR_INVAL);
                acc_cnt++;
            end
            held     = rsp_valid_o && !rsp_ready_i;
            held_rsp = rsp_o;
        end
    end

    initial begin
        seed        = 32'h08ff_f5c2;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b1;
        stall_en    = 1'b0;
        held        = 1'b0;
        sent_cnt    = 0;
        acc_cnt     = 0;
        rsp_cnt     = 0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_valid[s] = '0;
            m_plru[s]  = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_tag[s][w] = '0;
            end
        end
        // Random traffic drawn up front, eight tags per set
        for (int i = 0; i < N_RAND; i++) begin
            rnd                 = $random(seed);
            rand_req[i].op      = (rnd[7:5] == 3'd0) ? cache_dir_pkg::DIR_INVAL
                                                      : cache_dir_pkg::DIR_LOOKUP;
            rand_req[i].set_idx = cache_dir_pkg::set_t'(rnd[15:8]);
            rand_req[i].tag     = cache_dir_pkg::tag_t'(rnd[2:0]) | cache_dir_pkg::tag_t'(32'h0a0);
        end
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        // Fill set 3 way by way, then hit every way twice
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            send_req(cache_dir_pkg::DIR_LOOKUP, 3'd3, cache_dir_pkg::tag_t'(32'h100 + i));
        end
        for (int n = 0; n < 2 * `CACHE_WAYS; n++) begin
            send_req(cache_dir_pkg::DIR_LOOKUP, 3'd3,
                     cache_dir_pkg::tag_t'(32'h100 + (n % `CACHE_WAYS)));
        end
        // Full set, PLRU victims
        send_req(cache_dir_pkg::DIR_LOOKUP, 3'd3, 12'h200);
        send_req(cache_dir_pkg::DIR_LOOKUP, 3'd3, 12'h201);
        // Invalidate present, refill the freed way, invalidate absent
        send_req(cache_dir_pkg::DIR_INVAL, 3'd3, 12'h102);
        send_req(cache_dir_pkg::DIR_LOOKUP, 3'd3, 12'h300);
        send_req(cache_dir_pkg::DIR_INVAL, 3'd3, 12'h3ff);
        stall_en = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            send_req(rand_req[i].op, rand_req[i].set_idx, rand_req[i].tag);
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < TIMEOUT) begin
            wait_cnt++;
            @(negedge clk_i);
        end
        if (exp_q.size() != 0) begin
            fail_run("Responses still outstanding after the timeout");
        end else if (rsp_cnt == sent_cnt && acc_cnt == sent_cnt) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run("Number of responses does not match number of requests");
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
cache_dir_pkg.sv
prio_1hot_encoder.sv
cache_plru.sv
cache_tag_dir.sv
cache_dir_top.sv
tb_cache_dir.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_cache_dir
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
